/* source/id_decode_pkg.sv */
// shared opcodes, selector encodings and control word types for the decode stage
package id_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes and selector encodings
  ////////////////////////////////////////////////////////////////////////////

  // major opcodes of the supported classes
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_FENCE  = 7'h0f,  // misc-mem
    OPC_OPIMM  = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f,
    OPC_SYSTEM = 7'h73
  } opcode_e;

  // alu operators in the encoding the execute stage expects
  typedef enum logic [5:0] {
    ALU_ADD  = 6'b011000,
    ALU_SUB  = 6'b011001,
    ALU_XOR  = 6'b101111,
    ALU_OR   = 6'b101110,
    ALU_AND  = 6'b010101,
    ALU_SRA  = 6'b100100,
    ALU_SRL  = 6'b100101,
    ALU_SLL  = 6'b100111,
    ALU_LTS  = 6'b000000,  // branch compares
    ALU_LTU  = 6'b000001,
    ALU_GES  = 6'b001010,
    ALU_GEU  = 6'b001011,
    ALU_EQ   = 6'b001100,
    ALU_NE   = 6'b001101,
    ALU_SLTS = 6'b000010,  // set less than
    ALU_SLTU = 6'b000011
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG = 2'b00, OP_A_CURRPC = 2'b01, OP_A_IMM = 2'b10} op_a_sel_e;
  typedef enum logic {OP_B_REG = 1'b0, OP_B_IMM = 1'b1} op_b_sel_e;

  typedef enum logic [2:0] {
    IMMB_I      = 3'b000,
    IMMB_S      = 3'b001,
    IMMB_U      = 3'b010,
    IMMB_PCINCR = 3'b011,  // +4 for link address
    IMMB_SB     = 3'b100   // branch offset read by the target adder
  } imm_b_sel_e;

  typedef enum logic [1:0] {MD_OP_MULL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;
  typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_WRITE, CSR_OP_SET, CSR_OP_CLEAR} csr_op_e;
  typedef enum logic [1:0] {DT_WORD = 2'b00, DT_HALF = 2'b01, DT_BYTE = 2'b10} data_type_e;

  ////////////////////////////////////////////////////////////////////////////
  // instruction views
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;  // also csr address
    logic [4:0]  rs1;    // also zimm for csr*i
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  ////////////////////////////////////////////////////////////////////////////
  // control structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    logic       imm_a_zimm;  // op a imm is zimm, else zero
    imm_b_sel_e imm_b_sel;
    alu_op_e    operator;
  } alu_ctrl_t;

  typedef struct packed {
    logic       mult_en;
    logic       div_en;
    md_op_e     md_op;
    logic [1:0] signed_mode;  // {op b signed, op a signed}
  } md_ctrl_t;

  typedef struct packed {
    logic       req;
    logic       we;
    data_type_e data_type;
    logic       sign_ext;
  } lsu_ctrl_t;

  typedef struct packed {
    logic    csr_access;
    csr_op_e csr_op;
    logic    csr_status;  // mstatus touched
    logic    ecall;
    logic    ebrk;
    logic    mret;
    logic    pipe_flush;
  } sys_ctrl_t;

  typedef struct packed {
    alu_ctrl_t alu;
    md_ctrl_t  md;
    lsu_ctrl_t lsu;
    sys_ctrl_t sys;
    logic      rf_we;
    logic      jump;
    logic      branch;
    logic      illegal;
  } id_ctrl_t;

  // idle alu setting is register/register sltu
  localparam alu_ctrl_t ALU_CTRL_DEFAULT = '{
    op_a_sel:   OP_A_REG,
    op_b_sel:   OP_B_REG,
    imm_a_zimm: 1'b0,
    imm_b_sel:  IMMB_I,
    operator:   ALU_SLTU
  };

endpackage

/* source/alu_decode.sv */
// combinational decode of OP, OP-IMM, LUI and AUIPC, with optional RV32M support
`timescale 1ns/1ns
module alu_decode import id_decode_pkg::*; #(
  parameter bit RV32M_EN = 1'b1
) (
  input  instr_u    instr_i,
  output alu_ctrl_t alu_o,
  output md_ctrl_t  md_o,
  output logic      rf_we_o,
  output logic      illegal_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i.r.funct3;
  assign funct7 = instr_i.r.funct7;

  always_comb begin
    alu_o     = ALU_CTRL_DEFAULT;
    md_o      = '0;
    rf_we_o   = 1'b0;
    illegal_o = 1'b0;

    case (instr_i.r.opcode)
      OPC_LUI: begin
        alu_o.op_a_sel  = OP_A_IMM;  // zero + upper imm
        alu_o.op_b_sel  = OP_B_IMM;
        alu_o.imm_b_sel = IMMB_U;
        alu_o.operator  = ALU_ADD;
        rf_we_o         = 1'b1;
      end
      OPC_AUIPC: begin
        alu_o.op_a_sel  = OP_A_CURRPC;  // pc + upper imm
        alu_o.op_b_sel  = OP_B_IMM;
        alu_o.imm_b_sel = IMMB_U;
        alu_o.operator  = ALU_ADD;
        rf_we_o         = 1'b1;
      end
      OPC_OPIMM: begin
        alu_o.op_b_sel = OP_B_IMM;
        rf_we_o        = 1'b1;
        case (instr_i.i.funct3)
          3'b000: alu_o.operator = ALU_ADD;
          3'b010: alu_o.operator = ALU_SLTS;
          3'b011: alu_o.operator = ALU_SLTU;
          3'b100: alu_o.operator = ALU_XOR;
          3'b110: alu_o.operator = ALU_OR;
          3'b111: alu_o.operator = ALU_AND;
          3'b001: begin
            alu_o.operator = ALU_SLL;
            illegal_o      = (instr_i.i.imm12[11:5] != 7'b000_0000);  // shamt only
          end
          default: begin  // 3'b101, srl or sra
            if (instr_i.i.imm12[11:5] == 7'b010_0000) alu_o.operator = ALU_SRA;
            else if (instr_i.i.imm12[11:5] == 7'b000_0000) alu_o.operator = ALU_SRL;
            else illegal_o = 1'b1;
          end
        endcase
      end
      OPC_OP: begin
        rf_we_o = 1'b1;
        if (funct7[6]) begin
          illegal_o = 1'b1;  // no encodings with bit 31 set
        end else if (funct7 == 7'b000_0001) begin
          // rv32m, alu idles at add
          alu_o.operator = ALU_ADD;
          md_o.mult_en   = ~funct3[2];
          md_o.div_en    = funct3[2];
          if (funct3[2]) md_o.md_op = funct3[1] ? MD_OP_REM : MD_OP_DIV;
          else md_o.md_op = (funct3[1:0] == 2'b00) ? MD_OP_MULL : MD_OP_MULH;
          case (funct3)
            3'b001, 3'b100, 3'b110: md_o.signed_mode = 2'b11;  // mulh div rem
            3'b010:                 md_o.signed_mode = 2'b01;  // mulhsu
            default:                md_o.signed_mode = 2'b00;  // unsigned or low half
          endcase
          illegal_o = ~RV32M_EN;
        end else begin
          case ({funct7[5:0], funct3})
            {6'b00_0000, 3'b000}: alu_o.operator = ALU_ADD;
            {6'b10_0000, 3'b000}: alu_o.operator = ALU_SUB;
            {6'b00_0000, 3'b010}: alu_o.operator = ALU_SLTS;
            {6'b00_0000, 3'b011}: alu_o.operator = ALU_SLTU;
            {6'b00_0000, 3'b100}: alu_o.operator = ALU_XOR;
            {6'b00_0000, 3'b110}: alu_o.operator = ALU_OR;
            {6'b00_0000, 3'b111}: alu_o.operator = ALU_AND;
            {6'b00_0000, 3'b001}: alu_o.operator = ALU_SLL;
            {6'b00_0000, 3'b101}: alu_o.operator = ALU_SRL;
            {6'b10_0000, 3'b101}: alu_o.operator = ALU_SRA;
            default:              illegal_o      = 1'b1;
          endcase
        end
      end
      default: ;  // other classes, merge ignores us
    endcase
  end

endmodule

/* source/lsu_decode.sv */
// combinational decode of LOAD and STORE into address and data memory controls
`timescale 1ns/1ns
module lsu_decode import id_decode_pkg::*; (
  input  instr_u    instr_i,
  output alu_ctrl_t alu_o,
  output lsu_ctrl_t lsu_o,
  output logic      rf_we_o,
  output logic      illegal_o
);

  logic [2:0] funct3;
  data_type_e size;

  assign funct3 = instr_i.r.funct3;

  // access size from funct3[1:0]
  always_comb begin
    case (funct3[1:0])
      2'b00:   size = DT_BYTE;
      2'b01:   size = DT_HALF;
      default: size = DT_WORD;  // word, size 3 flagged below
    endcase
  end

  always_comb begin
    alu_o     = ALU_CTRL_DEFAULT;
    lsu_o     = '0;
    rf_we_o   = 1'b0;
    illegal_o = 1'b0;

    case (instr_i.r.opcode)
      OPC_LOAD: begin
        alu_o.op_b_sel  = OP_B_IMM;  // rs1 + i imm
        alu_o.imm_b_sel = IMMB_I;
        alu_o.operator  = ALU_ADD;
        lsu_o.req       = 1'b1;
        lsu_o.data_type = size;
        lsu_o.sign_ext  = ~funct3[2];  // lbu lhu zero extend
        rf_we_o         = 1'b1;
        illegal_o       = (funct3[1:0] == 2'b11);  // ld, rv64 only
      end
      OPC_STORE: begin
        alu_o.op_b_sel  = OP_B_IMM;  // rs1 + s imm
        alu_o.imm_b_sel = IMMB_S;
        alu_o.operator  = ALU_ADD;
        lsu_o.data_type = size;
        // reg offset, unsigned and size 3 stores have no encoding
        if (funct3[2] || funct3[1:0] == 2'b11) begin
          illegal_o = 1'b1;
        end else begin
          lsu_o.req = 1'b1;
          lsu_o.we  = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

/* source/flow_decode.sv */
// combinational decode of JAL, JALR and conditional branches
`timescale 1ns/1ns
module flow_decode import id_decode_pkg::*; (
  input  instr_u    instr_i,
  output alu_ctrl_t alu_o,
  output logic      rf_we_o,
  output logic      jump_o,
  output logic      branch_o,
  output logic      illegal_o
);

  always_comb begin
    alu_o     = ALU_CTRL_DEFAULT;
    rf_we_o   = 1'b0;
    jump_o    = 1'b0;
    branch_o  = 1'b0;
    illegal_o = 1'b0;

    case (instr_i.i.opcode)
      OPC_JAL, OPC_JALR: begin
        // link form, alu writes pc + 4 back
        alu_o.op_a_sel  = OP_A_CURRPC;
        alu_o.op_b_sel  = OP_B_IMM;
        alu_o.imm_b_sel = IMMB_PCINCR;
        alu_o.operator  = ALU_ADD;
        jump_o          = 1'b1;
        rf_we_o         = 1'b1;
        if (instr_i.i.opcode == OPC_JALR && instr_i.i.funct3 != 3'b000) begin
          jump_o    = 1'b0;
          rf_we_o   = 1'b0;
          illegal_o = 1'b1;
        end
      end
      OPC_BRANCH: begin
        branch_o        = 1'b1;
        alu_o.imm_b_sel = IMMB_SB;  // offset for the target adder
        case (instr_i.i.funct3)  // rs1 vs rs2 compare
          3'b000:  alu_o.operator = ALU_EQ;
          3'b001:  alu_o.operator = ALU_NE;
          3'b100:  alu_o.operator = ALU_LTS;
          3'b101:  alu_o.operator = ALU_GES;
          3'b110:  alu_o.operator = ALU_LTU;
          3'b111:  alu_o.operator = ALU_GEU;
          default: illegal_o      = 1'b1;  // 2 and 3 unused
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* source/system_decode.sv */
// combinational decode of SYSTEM (privileged and CSR) and MISC-MEM fence instructions
`timescale 1ns/1ns
module system_decode import id_decode_pkg::*; (
  input  instr_u    instr_i,
  output alu_ctrl_t alu_o,
  output sys_ctrl_t sys_o,
  output logic      rf_we_o,
  output logic      illegal_o
);

  localparam logic [11:0] CSR_MSTATUS = 12'h300;

  always_comb begin
    alu_o     = ALU_CTRL_DEFAULT;
    sys_o     = '0;
    rf_we_o   = 1'b0;
    illegal_o = 1'b0;

    case (instr_i.i.opcode)
      OPC_SYSTEM: begin
        if (instr_i.i.funct3 == 3'b000) begin
          // privileged, picked by imm12
          case (instr_i.i.imm12)
            12'h000: sys_o.ecall      = 1'b1;
            12'h001: sys_o.ebrk       = 1'b1;
            12'h302: sys_o.mret       = 1'b1;
            12'h105: sys_o.pipe_flush = 1'b1;  // wfi
            default: illegal_o        = 1'b1;
          endcase
        end else begin
          // csr read-modify-write, old value goes to rd
          sys_o.csr_access = 1'b1;
          rf_we_o          = 1'b1;
          alu_o.op_a_sel   = instr_i.i.funct3[2] ? OP_A_IMM : OP_A_REG;  // csr*i uses zimm
          alu_o.imm_a_zimm = 1'b1;
          alu_o.op_b_sel   = OP_B_IMM;
          alu_o.imm_b_sel  = IMMB_I;  // csr address in i imm
          case (instr_i.i.funct3[1:0])
            2'b01:   sys_o.csr_op = CSR_OP_WRITE;
            2'b10:   sys_o.csr_op = CSR_OP_SET;
            2'b11:   sys_o.csr_op = CSR_OP_CLEAR;
            default: illegal_o    = 1'b1;
          endcase
          sys_o.csr_status = ~illegal_o && (instr_i.i.imm12 == CSR_MSTATUS);
        end
      end
      OPC_FENCE: begin
        case (instr_i.i.funct3)
          3'b000:  ;                           // fence, in order core
          3'b001:  sys_o.pipe_flush = 1'b1;    // fence.i
          default: illegal_o        = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

endmodule

/* source/instr_decoder.sv */
// combinational instruction decoder, merges the class decoders and computes the RAW stall
`timescale 1ns/1ns
module instr_decoder import id_decode_pkg::*; #(
  parameter bit RV32M_EN = 1'b1
) (
  input  instr_u   instr_i,
  input  logic     raw_ra_i,     // rs1 hazard
  input  logic     raw_rb_i,     // rs2 hazard
  output id_ctrl_t decode_o,
  output logic     raw_stall_o
);

  alu_ctrl_t alu_alu, lsu_alu, flow_alu, sys_alu;
  md_ctrl_t  alu_md;
  lsu_ctrl_t lsu_ctrl;
  sys_ctrl_t sys_ctrl;
  logic      alu_we, lsu_we, flow_we, sys_we;
  logic      alu_ill, lsu_ill, flow_ill, sys_ill;
  logic      flow_jump, flow_branch;

  alu_decode #(.RV32M_EN(RV32M_EN)) u_alu_decode (
    .instr_i(instr_i), .alu_o(alu_alu), .md_o(alu_md), .rf_we_o(alu_we), .illegal_o(alu_ill)
  );
  lsu_decode u_lsu_decode (
    .instr_i(instr_i), .alu_o(lsu_alu), .lsu_o(lsu_ctrl), .rf_we_o(lsu_we), .illegal_o(lsu_ill)
  );
  flow_decode u_flow_decode (
    .instr_i(instr_i), .alu_o(flow_alu), .rf_we_o(flow_we), .jump_o(flow_jump),
    .branch_o(flow_branch), .illegal_o(flow_ill)
  );
  system_decode u_system_decode (
    .instr_i(instr_i), .alu_o(sys_alu), .sys_o(sys_ctrl), .rf_we_o(sys_we), .illegal_o(sys_ill)
  );

  ////////////////////////////////////////////////////////////////////////////
  // merge by opcode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    decode_o     = '0;
    decode_o.alu = ALU_CTRL_DEFAULT;
    case (instr_i.r.opcode)
      OPC_OP, OPC_OPIMM, OPC_LUI, OPC_AUIPC: begin
        {decode_o.alu, decode_o.md, decode_o.rf_we} = {alu_alu, alu_md, alu_we};
        decode_o.illegal                            = alu_ill;
      end
      OPC_LOAD, OPC_STORE: begin
        {decode_o.alu, decode_o.lsu, decode_o.rf_we, decode_o.illegal} =
          {lsu_alu, lsu_ctrl, lsu_we, lsu_ill};
      end
      OPC_JAL, OPC_JALR, OPC_BRANCH: begin
        {decode_o.alu, decode_o.rf_we, decode_o.jump, decode_o.branch, decode_o.illegal} =
          {flow_alu, flow_we, flow_jump, flow_branch, flow_ill};
      end
      OPC_SYSTEM, OPC_FENCE: begin
        {decode_o.alu, decode_o.sys, decode_o.rf_we, decode_o.illegal} =
          {sys_alu, sys_ctrl, sys_we, sys_ill};
      end
      default: decode_o.illegal = 1'b1;  // unknown opcode
    endcase

    // trapping instruction, no architectural side effects
    if (decode_o.illegal) begin
      decode_o.rf_we      = 1'b0;
      decode_o.lsu.req    = 1'b0;
      decode_o.md.mult_en = 1'b0;
      decode_o.md.div_en  = 1'b0;
      decode_o.sys.csr_op = CSR_OP_NONE;
      decode_o.jump       = 1'b0;
      decode_o.branch     = 1'b0;
    end
  end

  // stores read rs2 as write data even with an imm operand b
  assign raw_stall_o = (raw_ra_i && decode_o.alu.op_a_sel == OP_A_REG) ||
                       (raw_rb_i && decode_o.alu.op_b_sel == OP_B_REG) ||
                       (raw_rb_i && instr_i.r.opcode == OPC_STORE);

endmodule

/* source/id_issue_reg.sv */
// issue register toward execute, credit based flow control with one cycle latency
`timescale 1ns/1ns
module id_issue_reg import id_decode_pkg::*; #(
  parameter int unsigned NUM_CREDITS = 2
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     instr_valid_i,
  input  logic     raw_stall_i,
  input  id_ctrl_t decode_i,
  input  logic     credit_i,       // one slot freed in execute
  output logic     instr_ready_o,
  output logic     ctrl_valid_o,   // one pulse per issue
  output id_ctrl_t ctrl_o
);

  localparam int unsigned CNT_W = $clog2(NUM_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt_q;
  logic             accept;

  // no credit or operand hazard holds the instruction at fetch
  assign instr_ready_o = (credit_cnt_q != '0) && !raw_stall_i;
  assign accept        = instr_valid_i && instr_ready_o;

  // credit counter, issue takes one and a return gives one back
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt_q <= CNT_W'(NUM_CREDITS);
    end else begin
      case ({accept, credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - CNT_W'(1);
        2'b01:   credit_cnt_q <= credit_cnt_q + CNT_W'(1);
        default: ;  // both or neither
      endcase
    end
  end

  // output stage
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_valid_o <= 1'b0;
      ctrl_o       <= '0;
    end else begin
      ctrl_valid_o <= accept;
      if (accept) begin
        ctrl_o <= decode_i;  // held until next issue
      end
    end
  end

endmodule

/* source/id_stage.sv */
// decode stage top, combinational decoder feeding the credit-controlled issue register
`timescale 1ns/1ns
module id_stage import id_decode_pkg::*; #(
  parameter bit          RV32M_EN    = 1'b1,
  parameter int unsigned NUM_CREDITS = 2
) (
  input  logic     clk,
  input  logic     arst_n_i,
  // from fetch
  input  logic     instr_valid_i,
  input  instr_u   instr_i,
  input  logic     raw_ra_i,
  input  logic     raw_rb_i,
  output logic     instr_ready_o,
  // to execute
  output logic     ctrl_valid_o,
  output id_ctrl_t ctrl_o,
  input  logic     credit_i
);

  id_ctrl_t decode;
  logic     raw_stall;

  instr_decoder #(.RV32M_EN(RV32M_EN)) u_instr_decoder (
    .instr_i    (instr_i),
    .raw_ra_i   (raw_ra_i),
    .raw_rb_i   (raw_rb_i),
    .decode_o   (decode),
    .raw_stall_o(raw_stall)
  );

  id_issue_reg #(.NUM_CREDITS(NUM_CREDITS)) u_id_issue_reg (
    .clk(clk), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i), .raw_stall_i(raw_stall),
    .decode_i(decode), .credit_i(credit_i), .instr_ready_o(instr_ready_o),
    .ctrl_valid_o(ctrl_valid_o), .ctrl_o(ctrl_o)
  );

endmodule

/* tests/id_stage_sva.sv */
// bound checker for the decode stage, asserts the decode rules and the credit protocol at the ports
`timescale 1ns/1ns
module id_stage_sva import id_decode_pkg::*; #(
  parameter int unsigned NUM_CREDITS = 2
) (
  input logic     clk,
  input logic     arst_n_i,
  input logic     instr_valid_i,
  input instr_u   instr_i,
  input logic     raw_ra_i,
  input logic     raw_rb_i,
  input logic     instr_ready_i,
  input logic     ctrl_valid_i,
  input id_ctrl_t ctrl_i,
  input logic     credit_i
);

  int     fail_cnt = 0;  // polled by the testbench
  int     in_flight;     // issued minus returned
  logic   accept;
  instr_u last;          // word accepted on the previous edge

  assign accept = instr_valid_i && instr_ready_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_flight <= 0;
      last      <= '0;
    end else begin
      in_flight <= in_flight + int'(accept) - int'(credit_i);
      if (accept) last <= instr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // expected values from the encoding rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic bit reads_rs1(instr_u w);
    return w.i.opcode inside {OPC_OP, OPC_OPIMM, OPC_LOAD, OPC_STORE, OPC_BRANCH} ||
           (w.i.opcode == OPC_SYSTEM && w.i.funct3 != 3'b000 && !w.i.funct3[2]);  // csr reg
  endfunction

  function automatic bit reads_rs2(instr_u w);
    return w.i.opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};  // store data counts
  endfunction

  // encodings that have to trap
  function automatic bit must_trap(instr_u w);
    logic [2:0] f3;
    f3 = w.i.funct3;
    case (w.i.opcode)
      OPC_JALR:   return f3 != 3'b000;
      OPC_STORE:  return f3[1:0] == 2'b11;
      OPC_OPIMM:  return (f3 == 3'b001 && w.r.funct7 != 7'h00) ||
                         (f3 == 3'b101 && !(w.r.funct7 inside {7'h00, 7'h20}));
      OPC_SYSTEM: return (f3 == 3'b000) ?
                         !(w.i.imm12 inside {12'h000, 12'h001, 12'h302, 12'h105}) :
                         f3[1:0] == 2'b00;  // csr op 0
      OPC_LOAD, OPC_FENCE, OPC_AUIPC, OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JAL: return 1'b0;
      default:    return 1'b1;  // unknown opcode
    endcase
  endfunction

  function automatic bit fields_ok(instr_u w, id_ctrl_t c);
    logic [2:0] f3;
    f3 = w.i.funct3;
    if (c.illegal) return 1'b1;
    case (w.i.opcode)
      OPC_LOAD, OPC_STORE:
        return c.lsu.data_type == (f3[1:0] == 2'b00 ? DT_BYTE :
                                   f3[1:0] == 2'b01 ? DT_HALF : DT_WORD) &&
               (w.i.opcode == OPC_STORE || c.lsu.sign_ext == !f3[2]);
      OPC_OP: begin
        if (w.r.funct7 != 7'h01) return 1'b1;
        // {mul en, div en, op, mode}, mode bit 0 marks rs1 signed
        case (f3)
          3'd0:    return c.md == {2'b10, MD_OP_MULL, 2'b00};
          3'd1:    return c.md == {2'b10, MD_OP_MULH, 2'b11};
          3'd2:    return c.md == {2'b10, MD_OP_MULH, 2'b01};  // mulhsu
          3'd3:    return c.md == {2'b10, MD_OP_MULH, 2'b00};
          3'd4:    return c.md == {2'b01, MD_OP_DIV, 2'b11};
          3'd5:    return c.md == {2'b01, MD_OP_DIV, 2'b00};
          3'd6:    return c.md == {2'b01, MD_OP_REM, 2'b11};
          default: return c.md == {2'b01, MD_OP_REM, 2'b00};
        endcase
      end
      OPC_BRANCH:
        return c.alu.operator == (f3 == 3'd0 ? ALU_EQ  : f3 == 3'd1 ? ALU_NE  :
                                  f3 == 3'd4 ? ALU_LTS : f3 == 3'd5 ? ALU_GES :
                                  f3 == 3'd6 ? ALU_LTU : ALU_GEU);
      OPC_SYSTEM:
        if (f3 == 3'b000) begin
          return {c.sys.ecall, c.sys.ebrk, c.sys.mret, c.sys.pipe_flush} ==
                 {w.i.imm12 == 12'h000, w.i.imm12 == 12'h001,
                  w.i.imm12 == 12'h302, w.i.imm12 == 12'h105};
        end else begin
          return c.sys.csr_op == (f3[1:0] == 2'b01 ? CSR_OP_WRITE :
                                  f3[1:0] == 2'b10 ? CSR_OP_SET : CSR_OP_CLEAR) &&
                 c.sys.csr_status == (w.i.imm12 == 12'h300);  // mstatus
        end
      OPC_FENCE: return c.sys.pipe_flush == (f3 == 3'b001);  // fence.i
      default:   return 1'b1;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  a_issue_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_valid_i == $past(accept))
    else begin fail_cnt++; $error("FAILED at %0t: valid pulse does not match acceptance", $time); end

  a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
    in_flight >= 0 && in_flight <= int'(NUM_CREDITS))
    else begin fail_cnt++; $error("FAILED at %0t: %0d in flight", $time, in_flight); end

  a_credit_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    in_flight == int'(NUM_CREDITS) |-> !instr_ready_i)
    else begin fail_cnt++; $error("FAILED at %0t: ready with no credit left", $time); end

  a_raw_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_valid_i && ((raw_ra_i && reads_rs1(instr_i)) || (raw_rb_i && reads_rs2(instr_i)))
    |-> !instr_ready_i)
    else begin fail_cnt++; $error("FAILED at %0t: ready during a RAW hazard", $time); end

  a_trap_flagged: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_valid_i && must_trap(last) |-> ctrl_i.illegal)
    else begin fail_cnt++; $error("FAILED at %0t: %h issued as legal", $time, last); end

  a_trap_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_valid_i && ctrl_i.illegal |-> ctrl_i.sys.csr_op == CSR_OP_NONE &&
    !(ctrl_i.rf_we || ctrl_i.lsu.req || ctrl_i.md.mult_en || ctrl_i.md.div_en ||
      ctrl_i.jump || ctrl_i.branch))
    else begin fail_cnt++; $error("FAILED at %0t: illegal word with side effects", $time); end

  a_decode_fields: assert property (@(posedge clk) disable iff (!arst_n_i)
    ctrl_valid_i |-> fields_ok(last, ctrl_i))
    else begin fail_cnt++; $error("FAILED at %0t: wrong fields for %h", $time, last); end

endmodule

/* tests/id_stage_tb.sv */
// testbench for the decode stage, feeds an instruction list and counts the bound assertion failures
`timescale 1ns/1ns
module id_stage_tb import id_decode_pkg::*;;

  localparam int NUM_INSTR      = 48;
  localparam int NUM_GROUPS     = 6;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 200;

  // first index of each group, last entry closes the list
  localparam int GROUP_FIRST [NUM_GROUPS+1] = '{0, 9, 17, 25, 33, 42, 48};

  localparam logic [31:0] PROG [NUM_INSTR] = '{
    32'h003100b3, 32'h403100b3, 32'h003130b3, 32'h003140b3,  // add sub sltu xor
    32'h00510093, 32'h00311093, 32'h40315093,                // addi slli srai
    32'h123450b7, 32'h00001097,                              // lui auipc
    32'h023100b3, 32'h023110b3, 32'h023120b3, 32'h023130b3,  // mul mulh mulhsu mulhu
    32'h023140b3, 32'h023150b3, 32'h023160b3, 32'h023170b3,  // div divu rem remu
    32'h00410083, 32'h00411083, 32'h00412083,                // lb lh lw
    32'h00414083, 32'h00415083,                              // lbu lhu
    32'h00310423, 32'h00311423, 32'h00312423,                // sb sh sw
    32'h010000ef, 32'h000100e7,                              // jal jalr
    32'h00310463, 32'h00311463, 32'h00314463,                // beq bne blt
    32'h00315463, 32'h00316463, 32'h00317463,                // bge bltu bgeu
    32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073,  // ecall ebreak mret wfi
    32'h300110f3, 32'h304120f3, 32'h3002f0f3,                // csrrw csrrs csrrci
    32'h0ff0000f, 32'h0000100f,                              // fence fence.i
    32'h0000000b, 32'h000110e7, 32'h40311093,                // bad opcode, jalr f3, slli f7
    32'h00313423, 32'h300140f3, 32'h00200073                 // sd, csr op 0, bad imm12
  };

  string group_name [NUM_GROUPS] = '{"alu", "rv32m", "lsu", "flow", "system", "illegal"};

  logic     clk = 1'b0;
  logic     arst_n_i;
  logic     instr_valid_i;
  instr_u   instr_i;
  logic     raw_ra_i;
  logic     raw_rb_i;
  logic     instr_ready_o;
  logic     ctrl_valid_o;
  id_ctrl_t ctrl_o;
  logic     credit_i;

  integer seed = 32'h3051_52f3;
  int     cycle_cnt = 0;
  int     issued_cnt = 0;    // acceptances seen
  int     returned_cnt = 0;  // credits given back
  int     credit_due [$];    // cycle of each pending return

  id_stage #(.RV32M_EN(1'b1), .NUM_CREDITS(2)) DUT (
    .clk(clk), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .raw_ra_i(raw_ra_i), .raw_rb_i(raw_rb_i), .instr_ready_o(instr_ready_o),
    .ctrl_valid_o(ctrl_valid_o), .ctrl_o(ctrl_o), .credit_i(credit_i)
  );

  bind id_stage id_stage_sva #(.NUM_CREDITS(NUM_CREDITS)) u_id_stage_sva (
    .clk(clk), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .raw_ra_i(raw_ra_i), .raw_rb_i(raw_rb_i), .instr_ready_i(instr_ready_o),
    .ctrl_valid_i(ctrl_valid_o), .ctrl_i(ctrl_o), .credit_i(credit_i)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // execute model and run limit
  ////////////////////////////////////////////////////////////////////////////

  // one credit back 1 to 4 cycles after each issue, at most one per cycle
  always @(posedge clk) begin
    int due;
    #2;
    credit_i = 1'b0;
    if (credit_due.size() != 0 && credit_due[0] <= cycle_cnt) begin
      void'(credit_due.pop_front());
      credit_i = 1'b1;
      returned_cnt++;
    end
    if (ctrl_valid_o) begin
      due = cycle_cnt + 1 + ($random(seed) & 3);
      if (credit_due.size() != 0 && due <= credit_due[$]) due = credit_due[$] + 1;
      credit_due.push_back(due);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing the tests", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////////////////////////////////////////

  // present one word until it is taken, hazards clear at random while waiting
  task automatic issue_instr(input logic [31:0] word);
    bit taken;
    taken         = 1'b0;
    instr_valid_i = 1'b1;
    instr_i       = word;
    raw_ra_i      = ($random(seed) & 3) == 0;
    raw_rb_i      = ($random(seed) & 3) == 0;
    while (!taken) begin
      @(negedge clk);
      taken = instr_ready_o;  // stable mid cycle
      @(posedge clk);
      #2;
      if (taken) begin
        issued_cnt++;
      end else if ($random(seed) & 1) begin
        raw_ra_i = 1'b0;  // producer wrote back
        raw_rb_i = 1'b0;
      end
    end
    instr_valid_i = 1'b0;
    raw_ra_i      = 1'b0;
    raw_rb_i      = 1'b0;
  endtask

  // wait until every issued word has its credit back
  task automatic drain_pipe();
    while (returned_cnt != issued_cnt) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  initial begin
    int fails_before;
    int fails;
    int tests_failed;
    tests_failed  = 0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    raw_ra_i      = 1'b0;
    raw_rb_i      = 1'b0;
    credit_i      = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    arst_n_i = 1'b1;

    for (int g = 0; g < NUM_GROUPS; g++) begin
      fails_before = DUT.u_id_stage_sva.fail_cnt;
      for (int k = GROUP_FIRST[g]; k < GROUP_FIRST[g+1]; k++) issue_instr(PROG[k]);
      drain_pipe();
      fails = DUT.u_id_stage_sva.fail_cnt - fails_before;
      if (fails != 0) begin
        tests_failed++;
        $display("FAILED at %0t ns: test %s has %0d assertion failures",
                 $time, group_name[g], fails);
      end else begin
        $display("test %s passed, %0d instructions",
                 group_name[g], GROUP_FIRST[g+1] - GROUP_FIRST[g]);
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures in total",
             NUM_GROUPS, NUM_GROUPS - tests_failed, tests_failed,
             DUT.u_id_stage_sva.fail_cnt);
    if (tests_failed == 0 && DUT.u_id_stage_sva.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* id_stage.f */
source/id_decode_pkg.sv
source/alu_decode.sv
source/lsu_decode.sv
source/flow_decode.sv
source/system_decode.sv
source/instr_decoder.sv
source/id_issue_reg.sv
source/id_stage.sv
tests/id_stage_sva.sv
tests/id_stage_tb.sv
